//--- bench/ks_res_tb.sv
// --------------------------------------------------
// Table rows follow the block order, ks_loop 0, 3, 6
// A row with no results is the command a flush drops
// --------------------------------------------------
`timescale 1ns/1ps

module ks_res_tb;

  localparam int TIMEOUT = 300;
  localparam int ROW_NB  = 11;

  typedef struct packed {
    logic [2:0]  wp;
    logic [2:0]  rp;
    logic [2:0]  ks_loop;
    logic [11:0] seed;
    logic [1:0]  exp_res;
  } stim_row_t;

  logic                                      clk;
  logic                                      s_rst_n;
  logic [ks_res_pkg::KS_CMD_W-1:0]           cmd;
  logic                                      cmd_vld;
  logic                                      cmd_rdy;
  logic [ks_res_pkg::LWE_COEF_W-1:0]         coef;
  logic                                      coef_vld;
  logic                                      coef_rdy;
  logic [ks_res_pkg::KS_RESULT_W-1:0]        result;
  logic                                      result_vld;
  logic                                      result_rdy;
  logic                                      reg_wr;
  logic [ks_res_pkg::REG_ADDR_W-1:0]         reg_addr;
  logic [ks_res_pkg::REG_DATA_W-1:0]         reg_wdata;
  logic [ks_res_pkg::REG_DATA_W-1:0]         reg_rdata;

  // Model state and scoreboard
  logic [ks_res_pkg::LWE_COEF_W-1:0]         coef_q[$];
  ks_res_pkg::ks_result_t                    exp_q[$];
  logic [ks_res_pkg::BATCH_PBS_NB-1:0][ks_res_pkg::LWE_COEF_W-1:0] m_lwe;
  int m_blk;
  int m_x;
  int err_cnt;
  int chk_cnt;
  int to_cnt;
  int res_rx;
  int cmd_tx;

  ks_res_top ks_res_top_i (.*);

  always #5 clk = ~clk;

  // --------------------------------------------------
  // Stimulus table: wp, rp, ks_loop, seed, results
  // --------------------------------------------------
  function automatic stim_row_t stim_row(input int i);
    case (i)
      // First pass, batch sizes 4, 1, 2
      0:       return {3'd4, 3'd0, 3'd0, 12'h0a5, 2'd3};
      1:       return {3'd5, 3'd4, 3'd3, 12'h13c, 2'd3};
      2:       return {3'd7, 3'd5, 3'd6, 12'h2f0, 2'd1};
      // Second pass, pointers wrap
      3:       return {3'd2, 3'd7, 3'd0, 12'h366, 2'd3};
      4:       return {3'd6, 3'd2, 3'd3, 12'h4d1, 2'd3};
      5:       return {3'd7, 3'd6, 3'd6, 12'h58e, 2'd1};
      // Flush pass, row 7 sits in the FIFO at the flush
      6:       return {3'd1, 3'd7, 3'd0, 12'h627, 2'd3};
      7:       return {3'd4, 3'd1, 3'd3, 12'h7b9, 2'd0};
      8:       return {3'd3, 3'd0, 3'd0, 12'h84a, 2'd3};
      9:       return {3'd5, 3'd3, 3'd3, 12'h9d2, 2'd3};
      default: return {3'd1, 3'd5, 3'd6, 12'hae3, 2'd1};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d errors %0d timeouts %0d", chk_cnt, err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    to_cnt++;
    $display("Timeout while waiting for %s", what);
    finish_run();
  endtask

  // --------------------------------------------------
  // Reference loop, queues coefficients and results
  // --------------------------------------------------
  task automatic build_expected(input int first, input int last);
    stim_row_t r;
    ks_res_pkg::ks_result_t e;
    int n;
    int i;
    int bs;
    int idx;
    bit done;
    for (n = first; n <= last; n++) begin
      r = stim_row(n);
      // Pointer distance modulo twice the batch
      bs = (r.wp - r.rp) % (2 * ks_res_pkg::BATCH_PBS_NB);
      done = (r.exp_res == 0);
      while (!done) begin
        idx = m_blk * ks_res_pkg::LBX + m_x;
        if (idx == ks_res_pkg::LWE_K_P1 - 1) begin
          // Body, no result, loop wraps
          m_blk = 0;
          m_x = 0;
          done = 1'b1;
        end else begin
          // Slots at or above bs keep old values
          for (i = 0; i < bs; i++) begin
            m_lwe[i] = r.seed ^ $urandom();
            coef_q.push_back(m_lwe[i]);
          end
          e.lwe_a = m_lwe;
          e.ks_loop = idx;
          e.wp = r.wp;
          e.rp = r.rp;
          exp_q.push_back(e);
          m_x++;
          if (m_x == ks_res_pkg::LBX) begin
            m_x = 0;
            m_blk++;
            done = 1'b1;
          end
        end
      end
    end
  endtask

  // --------------------------------------------------
  // Stream drivers and result monitor
  // --------------------------------------------------
  task automatic drive_cmds(input int first, input int last);
    stim_row_t r;
    ks_res_pkg::ks_cmd_t c;
    int n;
    int t;
    @(posedge clk);
    #1;
    for (n = first; n <= last; n++) begin
      r = stim_row(n);
      c.wp = r.wp;
      c.rp = r.rp;
      c.ks_loop = r.ks_loop;
      cmd = c;
      cmd_vld = 1'b1;
      t = 0;
      @(negedge clk);
      while (!cmd_rdy) begin
        t++;
        if (t > TIMEOUT) begin
          timeout_fail("cmd_rdy");
        end
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
      // Flushed command never retires
      if (r.exp_res != 0) begin
        cmd_tx++;
      end
    end
  endtask

  task automatic drive_coefs();
    int t;
    @(posedge clk);
    #1;
    while (coef_q.size() > 0) begin
      coef = coef_q.pop_front();
      coef_vld = 1'b1;
      t = 0;
      @(negedge clk);
      while (!coef_rdy) begin
        t++;
        if (t > TIMEOUT) begin
          timeout_fail("coef_rdy");
        end
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      coef_vld = 1'b0;
    end
  endtask

  task automatic collect_results(input int n, input bit rand_bp);
    ks_res_pkg::ks_result_t got;
    ks_res_pkg::ks_result_t e;
    int got_n;
    int t;
    int i;
    got_n = 0;
    t = 0;
    @(posedge clk);
    #1;
    while (got_n < n) begin
      result_rdy = rand_bp ? (($urandom() % 3) != 0) : 1'b1;
      @(negedge clk);
      // Transfer lands on the next rising edge
      if (result_vld && result_rdy) begin
        got = result;
        e = exp_q.pop_front();
        for (i = 0; i < ks_res_pkg::BATCH_PBS_NB; i++) begin
          check_value($sformatf("result.lwe_a[%0d]", i), got.lwe_a[i], e.lwe_a[i]);
        end
        check_value("result.ks_loop", got.ks_loop, e.ks_loop);
        check_value("result.wp", got.wp, e.wp);
        check_value("result.rp", got.rp, e.rp);
        got_n++;
        res_rx++;
        t = 0;
      end else begin
        t++;
        if (t > TIMEOUT) begin
          timeout_fail("result_vld");
        end
      end
      @(posedge clk);
      #1;
    end
    result_rdy = 1'b1;
  endtask

  // No extra result once the queue is empty
  task automatic expect_idle();
    repeat (4) begin
      @(negedge clk);
      check_value("result_vld", result_vld, 1'b0);
    end
  endtask

  // --------------------------------------------------
  // Register port
  // --------------------------------------------------
  task automatic check_reg(input logic [1:0] addr, input int exp, input string name);
    @(posedge clk);
    #1;
    reg_addr = addr;
    @(posedge clk);
    @(negedge clk);
    check_value(name, reg_rdata, exp);
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
    @(posedge clk);
    #1;
    reg_wr = 1'b1;
    reg_addr = addr;
    reg_wdata = data;
    @(posedge clk);
    #1;
    reg_wr = 1'b0;
  endtask

  task automatic wait_cmd_count(input int exp);
    int t;
    t = 0;
    @(posedge clk);
    #1;
    reg_addr = ks_res_pkg::REG_CMD_CNT_ADDR;
    @(posedge clk);
    @(negedge clk);
    while (reg_rdata != exp) begin
      t++;
      if (t > TIMEOUT) begin
        timeout_fail("command count");
      end
      @(negedge clk);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    stim_row_t r;
    int i;
    int res_total;
    clk = 1'b0;
    s_rst_n = 1'b0;
    cmd = '0;
    cmd_vld = 1'b0;
    coef = '0;
    coef_vld = 1'b0;
    result_rdy = 1'b1;
    reg_wr = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    m_blk = 0;
    m_x = 0;
    err_cnt = 0;
    chk_cnt = 0;
    to_cnt = 0;
    res_rx = 0;
    cmd_tx = 0;
    void'($urandom(8805));
    repeat (2) @(posedge clk);
    #1;
    s_rst_n = 1'b1;

    // Idle state after reset
    @(negedge clk);
    check_value("result_vld", result_vld, 1'b0);
    check_value("cmd_rdy", cmd_rdy, 1'b1);
    check_value("coef_rdy", coef_rdy, 1'b1);
    check_reg(ks_res_pkg::REG_RES_CNT_ADDR, 0, "reg_rdata res_cnt");
    check_reg(ks_res_pkg::REG_CMD_CNT_ADDR, 0, "reg_rdata cmd_cnt");

    // Pass with result_rdy high, 7 results
    build_expected(0, 2);
    fork
      drive_cmds(0, 2);
      drive_coefs();
      collect_results(7, 1'b0);
    join
    // Pass under random back-pressure
    build_expected(3, 5);
    fork
      drive_cmds(3, 5);
      drive_coefs();
      collect_results(7, 1'b1);
    join
    expect_idle();
    check_reg(ks_res_pkg::REG_RES_CNT_ADDR, res_rx, "reg_rdata res_cnt");
    check_reg(ks_res_pkg::REG_CMD_CNT_ADDR, cmd_tx, "reg_rdata cmd_cnt");

    // Block 0 parked in the result FIFO, block 1 command pending
    @(posedge clk);
    #1;
    result_rdy = 1'b0;
    build_expected(6, 6);
    fork
      drive_cmds(6, 6);
      drive_coefs();
    join
    wait_cmd_count(cmd_tx);
    drive_cmds(7, 7);
    write_reg(ks_res_pkg::REG_CTRL_ADDR, 16'h0001);
    m_blk = 0;
    m_x = 0;
    // Let the drain finish
    repeat (4) @(posedge clk);
    build_expected(8, 10);
    fork
      drive_cmds(8, 10);
      drive_coefs();
      collect_results(10, 1'b1);
    join
    expect_idle();

    // Counters against the table
    res_total = 0;
    for (i = 0; i < ROW_NB; i++) begin
      r = stim_row(i);
      res_total += r.exp_res;
    end
    check_reg(ks_res_pkg::REG_RES_CNT_ADDR, res_total, "reg_rdata res_cnt");
    check_reg(ks_res_pkg::REG_CMD_CNT_ADDR, cmd_tx, "reg_rdata cmd_cnt");
    finish_run();
  end

endmodule

//--- ks_res.f
src/ks_res_pkg.sv
src/ks_fifo_reg.sv
src/ks_res_format.sv
src/ks_res_regs.sv
src/ks_res_top.sv
bench/ks_res_tb.sv

//--- src/ks_fifo_reg.sv
// --------------------------------------------------
// DEPTH must be 2 or more, no pass-through when full
// Storage has no reset, only the pointers do
// --------------------------------------------------
`timescale 1ns/1ps

module ks_fifo_reg #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             clk,
  input  logic             s_rst_n,

  input  logic [WIDTH-1:0] in_data,
  input  logic             in_vld,
  output logic             in_rdy,

  output logic [WIDTH-1:0] out_data,
  output logic             out_vld,
  input  logic             out_rdy
);

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------
  logic [DEPTH-1:0][WIDTH-1:0]   mem;
  logic [$clog2(DEPTH)-1:0]      wr_ptr;
  logic [$clog2(DEPTH)-1:0]      rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]    fill;

  logic push;
  logic pop;

  assign push = in_vld & in_rdy;
  assign pop  = out_vld & out_rdy;

  // Ready only on free space, independent of in_vld
  assign in_rdy  = fill != DEPTH;
  assign out_vld = fill != '0;
  // Head word straight from the register array
  assign out_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Circular pointers, any depth
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      fill <= '0;
    end else begin
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        // Push with pop keeps the level
        default: fill <= fill;
      endcase
    end
  end

endmodule

//--- src/ks_res_format.sv
// --------------------------------------------------
// Command ks_loop is trusted, not compared to the tracker
// Flush discards buffered inputs, result FIFO kept
// --------------------------------------------------
`timescale 1ns/1ps

module ks_res_format (
  input  logic                               clk,
  input  logic                               s_rst_n,

  input  logic [ks_res_pkg::KS_CMD_W-1:0]    cmd,
  input  logic                               cmd_vld,
  output logic                               cmd_rdy,

  input  logic [ks_res_pkg::LWE_COEF_W-1:0]  coef,
  input  logic                               coef_vld,
  output logic                               coef_rdy,

  input  logic                               flush,

  output logic [ks_res_pkg::KS_RESULT_W-1:0] result,
  output logic                               result_vld,
  input  logic                               result_rdy,

  output logic                               cmd_done,
  output logic                               result_done
);

  // --------------------------------------------------
  // Input buffering
  // --------------------------------------------------
  ks_res_pkg::ks_cmd_t                       s0_cmd;
  logic                                      s0_cmd_vld;
  logic                                      s0_cmd_rdy;
  logic [ks_res_pkg::LWE_COEF_W-1:0]         s0_coef;
  logic                                      s0_coef_vld;
  logic                                      s0_coef_rdy;

  ks_fifo_reg #(
    .WIDTH (ks_res_pkg::KS_CMD_W),
    .DEPTH (ks_res_pkg::CMD_FIFO_DEPTH)
  ) cmd_fifo_i (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  (cmd),
    .in_vld   (cmd_vld),
    .in_rdy   (cmd_rdy),
    .out_data (s0_cmd),
    .out_vld  (s0_cmd_vld),
    .out_rdy  (s0_cmd_rdy)
  );

  ks_fifo_reg #(
    .WIDTH (ks_res_pkg::LWE_COEF_W),
    .DEPTH (ks_res_pkg::COEF_FIFO_DEPTH)
  ) coef_fifo_i (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  (coef),
    .in_vld   (coef_vld),
    .in_rdy   (coef_rdy),
    .out_data (s0_coef),
    .out_vld  (s0_coef_vld),
    .out_rdy  (s0_coef_rdy)
  );

  // --------------------------------------------------
  // Flush drain
  // --------------------------------------------------
  logic drain_q;
  logic drain;

  // Held until both input heads run dry
  assign drain = flush | drain_q;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      drain_q <= 1'b0;
    end else begin
      drain_q <= drain & (s0_cmd_vld | s0_coef_vld);
    end
  end

  // --------------------------------------------------
  // Loop tracker
  // --------------------------------------------------
  logic [ks_res_pkg::KS_BLOCK_W-1:0]         blk_cnt;
  logic [ks_res_pkg::LBX_W-1:0]              x_cnt;
  logic                                      last_blk;
  logic                                      last_x;
  logic                                      is_body;
  logic                                      do_inc;
  ks_res_pkg::ks_result_t                    res_in;
  logic                                      res_in_vld;
  logic                                      res_in_rdy;

  assign last_blk = blk_cnt == ks_res_pkg::KS_BLOCK_COL_NB - 1;
  // Last block is shorter, it stops at the body
  assign last_x   = last_blk ? (x_cnt == ks_res_pkg::LAST_X) : (x_cnt == ks_res_pkg::LBX - 1);
  assign is_body  = last_blk & last_x;
  assign do_inc   = (is_body & s0_cmd_vld) | (res_in_vld & res_in_rdy);

  always_ff @(posedge clk) begin
    if (!s_rst_n || drain) begin
      blk_cnt <= '0;
      x_cnt   <= '0;
    end else if (do_inc) begin
      x_cnt <= last_x ? '0 : x_cnt + 1'b1;
      if (last_x) begin
        blk_cnt <= last_blk ? '0 : blk_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Batch gatherer
  // --------------------------------------------------
  logic [ks_res_pkg::BPBS_SIZE_W-1:0]        coef_cnt;
  logic [ks_res_pkg::BPBS_SIZE_W-1:0]        bsize_m1;
  logic                                      last_coef;
  logic                                      coef_take;
  logic [ks_res_pkg::BATCH_PBS_NB-1:0][ks_res_pkg::LWE_COEF_W-1:0] lwe_a;
  logic [ks_res_pkg::BATCH_PBS_NB-1:0][ks_res_pkg::LWE_COEF_W-1:0] lwe_d;

  assign bsize_m1  = ks_res_pkg::batch_size(s0_cmd.wp, s0_cmd.rp) - 1'b1;
  assign last_coef = coef_cnt == bsize_m1;

  // Last coefficient only leaves with room for its result
  assign s0_coef_rdy = drain | (s0_cmd_vld & ~is_body & (~last_coef | res_in_rdy));
  assign coef_take   = s0_coef_vld & s0_coef_rdy & ~drain;
  // Retire on the body or on the last result of the block
  assign s0_cmd_rdy  = drain | is_body | (res_in_rdy & s0_coef_vld & last_coef & last_x);

  always_ff @(posedge clk) begin
    if (!s_rst_n || drain) begin
      coef_cnt <= '0;
    end else if (coef_take) begin
      coef_cnt <= last_coef ? '0 : coef_cnt + 1'b1;
    end
  end

  // Slots past the batch size keep old values
  always_comb begin
    for (int i = 0; i < ks_res_pkg::BATCH_PBS_NB; i++) begin
      lwe_d[i] = (coef_take && coef_cnt == i) ? s0_coef : lwe_a[i];
    end
  end

  always_ff @(posedge clk) begin
    lwe_a <= lwe_d;
  end

  // --------------------------------------------------
  // Result build and output buffering
  // --------------------------------------------------
  assign res_in_vld     = s0_cmd_vld & ~is_body & s0_coef_vld & last_coef & ~drain;
  // Bypass so the last coefficient lands in this result
  assign res_in.lwe_a   = lwe_d;
  assign res_in.ks_loop = ks_res_pkg::loop_index(blk_cnt, x_cnt);
  assign res_in.wp      = s0_cmd.wp;
  assign res_in.rp      = s0_cmd.rp;

  ks_fifo_reg #(
    .WIDTH (ks_res_pkg::KS_RESULT_W),
    .DEPTH (ks_res_pkg::RES_FIFO_DEPTH)
  ) res_fifo_i (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_data  (res_in),
    .in_vld   (res_in_vld),
    .in_rdy   (res_in_rdy),
    .out_data (result),
    .out_vld  (result_vld),
    .out_rdy  (result_rdy)
  );

  // Event pulses for the counters
  assign cmd_done    = s0_cmd_vld & s0_cmd_rdy & ~drain;
  assign result_done = res_in_vld & res_in_rdy;

endmodule

//--- src/ks_res_pkg.sv
// --------------------------------------------------
// Batch pointers wrap at 2*BATCH_PBS_NB, a power of 2
// wp equal to rp is not a legal batch
// --------------------------------------------------
package ks_res_pkg;

  // --------------------------------------------------
  // Batch and coefficient sizes
  // --------------------------------------------------
  localparam int BATCH_PBS_NB = 4;
  localparam int BPBS_PTR_W   = 3;
  // Holds a batch size of 1 up to BATCH_PBS_NB
  localparam int BPBS_SIZE_W  = $clog2(BATCH_PBS_NB + 1);
  localparam int LWE_COEF_W   = 12;

  // --------------------------------------------------
  // Loop geometry
  // --------------------------------------------------
  localparam int LBX             = 3;
  localparam int LBX_W           = $clog2(LBX);
  // Mask positions plus the body
  localparam int LWE_K_P1        = 8;
  localparam int KS_BLOCK_COL_NB = (LWE_K_P1 + LBX - 1) / LBX;
  localparam int KS_BLOCK_W      = $clog2(KS_BLOCK_COL_NB);
  // Body slot inside the last, shorter block
  localparam int LAST_X          = (LWE_K_P1 % LBX) == 0 ? LBX - 1 : (LWE_K_P1 % LBX) - 1;
  localparam int KS_LOOP_W       = 3;

  // Buffer depths
  localparam int CMD_FIFO_DEPTH  = 4;
  localparam int COEF_FIFO_DEPTH = 2;
  localparam int RES_FIFO_DEPTH  = 4;

  // Register map
  localparam int REG_ADDR_W       = 2;
  localparam int REG_DATA_W       = 16;
  localparam int REG_CTRL_ADDR    = 0;
  localparam int REG_RES_CNT_ADDR = 1;
  localparam int REG_CMD_CNT_ADDR = 2;

  // --------------------------------------------------
  // Words
  // --------------------------------------------------
  typedef struct packed {
    logic [BPBS_PTR_W-1:0] wp;
    logic [BPBS_PTR_W-1:0] rp;
    logic [KS_LOOP_W-1:0]  ks_loop;
  } ks_cmd_t;

  typedef struct packed {
    logic [BATCH_PBS_NB-1:0][LWE_COEF_W-1:0] lwe_a;
    logic [KS_LOOP_W-1:0]                    ks_loop;
    logic [BPBS_PTR_W-1:0]                   wp;
    logic [BPBS_PTR_W-1:0]                   rp;
  } ks_result_t;

  localparam int KS_CMD_W    = $bits(ks_cmd_t);
  localparam int KS_RESULT_W = $bits(ks_result_t);

  // Pointer distance, wraps with the pointer width
  function automatic logic [BPBS_SIZE_W-1:0] batch_size(
    input logic [BPBS_PTR_W-1:0] wp,
    input logic [BPBS_PTR_W-1:0] rp
  );
    logic [BPBS_PTR_W-1:0] diff;
    diff = wp - rp;
    return BPBS_SIZE_W'(diff);
  endfunction

  // Flat loop index from block and slot
  function automatic logic [KS_LOOP_W-1:0] loop_index(
    input logic [KS_BLOCK_W-1:0] blk,
    input logic [LBX_W-1:0]      x
  );
    logic [KS_LOOP_W-1:0] idx;
    idx = KS_LOOP_W'(blk) * KS_LOOP_W'(LBX) + KS_LOOP_W'(x);
    return idx;
  endfunction

endpackage

//--- src/ks_res_regs.sv
// --------------------------------------------------
// Single-cycle port, read data one cycle after address
// Counters wrap, flush bit self-clears
// --------------------------------------------------
`timescale 1ns/1ps

module ks_res_regs (
  input  logic                              clk,
  input  logic                              s_rst_n,

  input  logic                              reg_wr,
  input  logic [ks_res_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [ks_res_pkg::REG_DATA_W-1:0] reg_wdata,
  output logic [ks_res_pkg::REG_DATA_W-1:0] reg_rdata,

  output logic                              flush,
  input  logic                              cmd_done,
  input  logic                              result_done
);

  // --------------------------------------------------
  // Write decode
  // --------------------------------------------------
  logic ctrl_wr;

  assign ctrl_wr = reg_wr && (reg_addr == ks_res_pkg::REG_CTRL_ADDR);

  // One-cycle pulse, bit 0 of the control word
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      flush <= 1'b0;
    end else begin
      flush <= ctrl_wr & reg_wdata[0];
    end
  end

  // --------------------------------------------------
  // Event counters
  // --------------------------------------------------
  logic [ks_res_pkg::REG_DATA_W-1:0] res_cnt;
  logic [ks_res_pkg::REG_DATA_W-1:0] cmd_cnt;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      res_cnt <= '0;
      cmd_cnt <= '0;
    end else begin
      // Wrap at full width
      if (result_done) begin
        res_cnt <= res_cnt + 1'b1;
      end
      if (cmd_done) begin
        cmd_cnt <= cmd_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      reg_rdata <= '0;
    end else begin
      case (reg_addr)
        ks_res_pkg::REG_RES_CNT_ADDR: reg_rdata <= res_cnt;
        ks_res_pkg::REG_CMD_CNT_ADDR: reg_rdata <= cmd_cnt;
        // Control reads back as zero
        default:                      reg_rdata <= '0;
      endcase
    end
  end

endmodule

//--- src/ks_res_top.sv
// --------------------------------------------------
// All streams valid/ready, no stage added here
// --------------------------------------------------
`timescale 1ns/1ps

module ks_res_top (
  input  logic                               clk,
  input  logic                               s_rst_n,

  // Command stream
  input  logic [ks_res_pkg::KS_CMD_W-1:0]    cmd,
  input  logic                               cmd_vld,
  output logic                               cmd_rdy,

  // Coefficient stream
  input  logic [ks_res_pkg::LWE_COEF_W-1:0]  coef,
  input  logic                               coef_vld,
  output logic                               coef_rdy,

  // Result stream
  output logic [ks_res_pkg::KS_RESULT_W-1:0] result,
  output logic                               result_vld,
  input  logic                               result_rdy,

  // Register port
  input  logic                               reg_wr,
  input  logic [ks_res_pkg::REG_ADDR_W-1:0]  reg_addr,
  input  logic [ks_res_pkg::REG_DATA_W-1:0]  reg_wdata,
  output logic [ks_res_pkg::REG_DATA_W-1:0]  reg_rdata
);

  // --------------------------------------------------
  // Formatter to register block
  // --------------------------------------------------
  logic flush;
  logic cmd_done;
  logic result_done;

  ks_res_format ks_res_format_i (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .cmd         (cmd),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .coef        (coef),
    .coef_vld    (coef_vld),
    .coef_rdy    (coef_rdy),
    .flush       (flush),
    .result      (result),
    .result_vld  (result_vld),
    .result_rdy  (result_rdy),
    .cmd_done    (cmd_done),
    .result_done (result_done)
  );

  // Flush control and event counters
  ks_res_regs ks_res_regs_i (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .reg_wr      (reg_wr),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .flush       (flush),
    .cmd_done    (cmd_done),
    .result_done (result_done)
  );

endmodule
